// File: include/exec_assert.svh
`ifndef EXEC_ASSERT_SVH
`define EXEC_ASSERT_SVH

// Labelled concurrent check on the rising edge
// Disabled while reset is high, reports through $error
`define EXEC_ASSERT(label, clk, rst, prop, msg) \
	label: assert property (@(posedge clk) disable iff (rst) prop) \
		else $error("%m: %s", msg);

`endif

// File: project.f
+incdir+include
verilog/exec_pkg.sv
verilog/exec_regfile.sv
verilog/exec_operand_muxes.sv
verilog/exec_fwd_ctrl.sv
verilog/exec_alu.sv
verilog/exec_mul.sv
verilog/exec_freeze_ctrl.sv
verilog/exec_top.sv
verif/exec_tb.sv

// File: verif/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

	import exec_pkg::*;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 8;
	localparam int DIRECT_INSTR = 20;
	localparam int RAND_INSTR   = 400;
	localparam int SEED         = 32'h074b736a;
	// Worst case every slot is a multiply, plus reset and drain
	localparam longint WATCHDOG_NS = longint'(DIRECT_INSTR + RAND_INSTR + RESET_CYCLES + 50)
		* (MUL_CYCLES + 4) * CLK_PERIOD;

	logic      clk;
	logic      reset;
	logic      in_valid;
	opcode_t   in_op;
	reg_addr_t in_rd;
	reg_addr_t in_ra;
	reg_addr_t in_rb;
	word_t     in_imm;
	logic      in_use_imm;
	logic      in_ready;
	logic      out_valid;
	reg_addr_t out_rd;
	word_t     out_data;

	// Reference model, architectural registers and pending results
	word_t     model_regs [REG_N];
	reg_addr_t exp_rd_q [$];
	word_t     exp_data_q [$];
	bit        exp_mul_q [$];
	logic      mul_pending;
	logic      accepted;

	exec_top dut0 (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_op      (in_op),
		.in_rd      (in_rd),
		.in_ra      (in_ra),
		.in_rb      (in_rb),
		.in_imm     (in_imm),
		.in_use_imm (in_use_imm),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_rd     (out_rd),
		.out_data   (out_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "Run stopped at the first failed check");
	endtask

	task automatic check_result(input reg_addr_t exp_rd, input word_t exp_data);
		if (out_rd !== exp_rd || out_data !== exp_data) begin
			report_failure($sformatf("Mismatch at %0t ns: result r%0d = %08h, expected r%0d = %08h",
				$time, out_rd, out_data, exp_rd, exp_data));
		end
	endtask

	task automatic check_ready(input logic exp_ready);
		if (in_ready !== exp_ready) begin
			report_failure($sformatf("Mismatch at %0t ns: in_ready = %b, expected %b",
				$time, in_ready, exp_ready));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic word_t ref_result(input opcode_t op, input word_t a, input word_t b);
		word_t r;
		case (op)
			OP_ADD:  r = a + b;
			OP_SUB:  r = a - b;
			OP_AND:  r = a & b;
			OP_OR:   r = a | b;
			OP_XOR:  r = a ^ b;
			OP_SLL:  r = a << b[SHAMT_W-1:0];
			OP_SRL:  r = a >> b[SHAMT_W-1:0];
			// Low half of the full product
			default: r = a * b;
		endcase
		return r;
	endfunction

	// Runs the instruction on the issue port in issue order
	task automatic record_accept();
		word_t a;
		word_t b;
		word_t r;
		a = model_regs[in_ra];
		b = in_use_imm ? in_imm : model_regs[in_rb];
		r = ref_result(in_op, a, b);
		// r0 still shows up on the result port
		if (in_rd != '0) begin
			model_regs[in_rd] = r;
		end
		exp_rd_q.push_back(in_rd);
		exp_data_q.push_back(r);
		exp_mul_q.push_back(in_op == OP_MUL);
		if (in_op == OP_MUL) begin
			mul_pending = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// One clock: sample at the falling edge, drive 1 ns after the rising edge
	task automatic step_cycle();
		bit was_mul;
		@(negedge clk);
		if (out_valid) begin
			if (exp_rd_q.size() == 0) begin
				report_failure("A result appeared with no instruction outstanding");
			end else begin
				check_result(exp_rd_q.pop_front(), exp_data_q.pop_front());
				was_mul = exp_mul_q.pop_front();
				if (was_mul) begin
					mul_pending = 1'b0;
				end
			end
		end
		// Issue port stalls only from MUL acceptance until its result
		check_ready(!mul_pending);
		accepted = in_valid && in_ready;
		if (accepted) begin
			record_accept();
		end
		@(posedge clk);
		#1;
	endtask

	// Holds the instruction on the port until it is taken
	task automatic issue_instr(input opcode_t op, input reg_addr_t rd, input reg_addr_t ra,
		input reg_addr_t rb, input word_t imm, input logic use_imm);
		in_valid   = 1'b1;
		in_op      = op;
		in_rd      = rd;
		in_ra      = ra;
		in_rb      = rb;
		in_imm     = imm;
		in_use_imm = use_imm;
		do begin
			step_cycle();
		end while (!accepted);
		in_valid = 1'b0;
	endtask

	// Junk fields with valid low must not reach any register
	task automatic insert_bubble();
		in_valid = 1'b0;
		in_op    = opcode_t'($urandom_range(0, 7));
		in_rd    = reg_addr_t'($urandom_range(1, REG_N - 1));
		step_cycle();
	endtask

	// Small range so that back-to-back dependencies are common
	function automatic reg_addr_t pick_reg();
		return reg_addr_t'($urandom_range(0, 5));
	endfunction

	initial begin
		void'($urandom(SEED));
		clk         = 1'b0;
		reset       = 1'b1;
		in_valid    = 1'b0;
		in_op       = OP_ADD;
		in_rd       = '0;
		in_ra       = '0;
		in_rb       = '0;
		in_imm      = '0;
		in_use_imm  = 1'b0;
		mul_pending = 1'b0;
		accepted    = 1'b0;
		for (int i = 0; i < REG_N; i++) begin
			model_regs[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		// Idle after reset, expects no result and a ready port
		repeat (3) step_cycle();
		// Seed r1..r5 through the immediate path
		for (int r = 1; r < 6; r++) begin
			issue_instr(OP_OR, reg_addr_t'(r), '0, '0, $urandom, 1'b1);
		end
		// Every opcode with an immediate B
		for (int op = 0; op < 8; op++) begin
			issue_instr(opcode_t'(op), 4'd6, 4'd1, 4'd0, $urandom, 1'b1);
		end
		// Multiply then a consumer of its product
		issue_instr(OP_MUL, 4'd7, 4'd2, 4'd3, '0, 1'b0);
		issue_instr(OP_ADD, 4'd8, 4'd7, 4'd7, '0, 1'b0);
		// Write r0, then read it on both sources
		issue_instr(OP_ADD, 4'd0, 4'd1, 4'd2, '0, 1'b0);
		issue_instr(OP_OR, 4'd9, 4'd0, 4'd0, '0, 1'b0);
		// Random mix with bubbles
		for (int i = 0; i < RAND_INSTR; i++) begin
			if ($urandom_range(0, 4) == 0) begin
				insert_bubble();
			end else begin
				issue_instr(opcode_t'($urandom_range(0, 7)), pick_reg(), pick_reg(), pick_reg(),
					$urandom, 1'($urandom_range(0, 1)));
			end
		end
		// Long enough for a trailing multiply to finish
		repeat (MUL_CYCLES + 8) step_cycle();
		if (exp_rd_q.size() != 0) begin
			report_failure($sformatf("%0d results never appeared on the result port",
				exp_rd_q.size()));
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		report_failure("Timeout: the test sequence did not finish in time");
	end

endmodule

`default_nettype wire

// File: verilog/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
	input  wire exec_pkg::opcode_t op,
	input  wire exec_pkg::word_t   operand_a,
	input  wire exec_pkg::word_t   operand_b,
	output exec_pkg::word_t        result
);

	import exec_pkg::*;

	// Shift amount from the low bits of B
	logic [SHAMT_W-1:0] shamt;

	assign shamt = operand_b[SHAMT_W-1:0];

	always_comb begin
		case (op)
			OP_ADD:  result = operand_a + operand_b;
			OP_SUB:  result = operand_a - operand_b;
			OP_AND:  result = operand_a & operand_b;
			OP_OR:   result = operand_a | operand_b;
			OP_XOR:  result = operand_a ^ operand_b;
			// Logical shifts only
			OP_SLL:  result = operand_a << shamt;
			OP_SRL:  result = operand_a >> shamt;
			// Product comes from the multiplier
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/exec_freeze_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_assert.svh"

module exec_freeze_ctrl (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    ex_valid,
	input  wire exec_pkg::opcode_t ex_op,
	input  wire                    mul_done,
	output logic                   id_freeze,
	output logic                   ex_freeze,
	output logic                   mul_start
);

	import exec_pkg::*;

	frz_state_t state;
	frz_state_t state_nxt;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FRZ_RUN;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			FRZ_RUN:    if (mul_start) state_nxt = FRZ_MUL;
			FRZ_MUL:    if (mul_done) state_nxt = FRZ_FINISH;
			// One cycle for EX to hand the product to WB
			FRZ_FINISH: state_nxt = FRZ_RUN;
			default:    state_nxt = FRZ_RUN;
		endcase
	end

	// Freeze from the first cycle the multiply sits in EX
	assign mul_start = state == FRZ_RUN && ex_valid && ex_op == OP_MUL;
	assign ex_freeze = mul_start || state == FRZ_MUL;
	assign id_freeze = ex_freeze || state == FRZ_FINISH;

	`EXEC_ASSERT(a_ex_implies_id, clk, reset, ex_freeze |-> id_freeze,
		"EX frozen while ID runs")
	`EXEC_ASSERT(a_done_in_mul, clk, reset, mul_done |-> state == FRZ_MUL,
		"multiplier done outside the multiply state")

endmodule

`default_nettype wire

// File: verilog/exec_fwd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exec_fwd_ctrl (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      id_freeze,
	input  wire                      ex_freeze,
	input  wire                      in_valid,
	input  wire exec_pkg::reg_addr_t in_rd,
	input  wire exec_pkg::reg_addr_t in_ra,
	input  wire exec_pkg::reg_addr_t in_rb,
	input  wire                      in_use_imm,
	output exec_pkg::sel_t           sel_a,
	output exec_pkg::sel_t           sel_b,
	output logic                     ex_valid,
	output exec_pkg::reg_addr_t      ex_rd,
	output logic                     wb_valid,
	output exec_pkg::reg_addr_t      wb_rd
);

	import exec_pkg::*;

	// Instruction taken from the issue port this cycle
	logic issue;

	assign issue = in_valid && !id_freeze;

	// Destination tag pipeline, moves with the operand registers
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
			ex_rd    <= '0;
			wb_valid <= 1'b0;
			wb_rd    <= '0;
		end else if (!ex_freeze) begin
			ex_valid <= issue;
			ex_rd    <= in_rd;
			wb_valid <= ex_valid;
			wb_rd    <= ex_rd;
		end else begin
			// EX held, WB empties so nothing writes twice
			wb_valid <= 1'b0;
		end
	end

	// Source lookup, EX beats WB and r0 stays on the register file
	function automatic sel_t fwd_src(input reg_addr_t src);
		sel_t sel;
		sel = SEL_RF;
		if (src != '0 && ex_valid && ex_rd == src) begin
			sel = SEL_EX_FORW;
		end else if (src != '0 && wb_valid && wb_rd == src) begin
			sel = SEL_WB_FORW;
		end
		return sel;
	endfunction

	assign sel_a = fwd_src(in_ra);
	assign sel_b = in_use_imm ? SEL_IMM : fwd_src(in_rb);

endmodule

`default_nettype wire

// File: verilog/exec_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_assert.svh"

module exec_mul (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  start,
	input  wire exec_pkg::word_t operand_a,
	input  wire exec_pkg::word_t operand_b,
	output exec_pkg::word_t      product,
	output logic                 busy,
	output logic                 done
);

	import exec_pkg::*;

	logic [MUL_CNT_W-1:0] cnt;
	word_t mcand;
	word_t mplier;
	word_t acc;
	word_t addend;
	logic  last;

	// Partial product for the current multiplier bit
	assign addend = mplier[0] ? mcand : '0;
	assign last   = cnt == MUL_CNT_W'(MUL_CYCLES - 1);

	// Iteration control and accumulator
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
			acc  <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt  <= '0;
				acc  <= '0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				acc <= acc + addend;
				if (last) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Shift registers, only the low 32 bits are kept
	always_ff @(posedge clk) begin
		if (start) begin
			mcand  <= operand_a;
			mplier <= operand_b;
		end else if (busy) begin
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	// Holds until the next start
	assign product = acc;

	`EXEC_ASSERT(a_no_restart, clk, reset, start |-> !busy,
		"multiply started while one is running")

endmodule

`default_nettype wire

// File: verilog/exec_operand_muxes.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_assert.svh"

module exec_operand_muxes (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  id_freeze,
	input  wire                  ex_freeze,
	input  wire exec_pkg::word_t rf_dataa,
	input  wire exec_pkg::word_t rf_datab,
	input  wire exec_pkg::word_t ex_forw,
	input  wire exec_pkg::word_t wb_forw,
	input  wire exec_pkg::word_t simm,
	input  wire exec_pkg::sel_t  sel_a,
	input  wire exec_pkg::sel_t  sel_b,
	output exec_pkg::word_t      operand_a,
	output exec_pkg::word_t      operand_b
);

	import exec_pkg::*;

	word_t muxed_a;
	word_t muxed_b;

	// Index 0 is operand A, index 1 is operand B
	word_t muxed [2];
	word_t operand [2];
	logic  saved [2];

	////////////////////////////////////////////////////////////
	// Forwarding muxes
	////////////////////////////////////////////////////////////

	// A never takes the immediate
	always_comb begin
		case (sel_a)
			SEL_EX_FORW: muxed_a = ex_forw;
			SEL_WB_FORW: muxed_a = wb_forw;
			default:     muxed_a = rf_dataa;
		endcase
	end

	always_comb begin
		case (sel_b)
			SEL_IMM:     muxed_b = simm;
			SEL_EX_FORW: muxed_b = ex_forw;
			SEL_WB_FORW: muxed_b = wb_forw;
			default:     muxed_b = rf_datab;
		endcase
	end

	assign muxed[0] = muxed_a;
	assign muxed[1] = muxed_b;

	////////////////////////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////////////////////////

	// ID frozen with EX running: capture once and keep it
	// Both freezes low: follow the mux and drop the saved flag
	for (genvar i = 0; i < 2; i++) begin : g_opreg
		always_ff @(posedge clk) begin
			if (reset) begin
				operand[i] <= '0;
				saved[i]   <= 1'b0;
			end else if (!ex_freeze) begin
				if (!id_freeze) begin
					operand[i] <= muxed[i];
					saved[i]   <= 1'b0;
				end else if (!saved[i]) begin
					operand[i] <= muxed[i];
					saved[i]   <= 1'b1;
				end
			end
		end
	end

	assign operand_a = operand[0];
	assign operand_b = operand[1];

	`EXEC_ASSERT(a_opa_follows_mux, clk, reset,
		(!id_freeze && !ex_freeze) |=> operand_a == $past(muxed_a),
		"operand A missed the mux choice while running")
	`EXEC_ASSERT(a_opb_follows_mux, clk, reset,
		(!id_freeze && !ex_freeze) |=> operand_b == $past(muxed_b),
		"operand B missed the mux choice while running")
	`EXEC_ASSERT(a_sel_a_no_imm, clk, reset, sel_a != SEL_IMM,
		"immediate selected for operand A")

endmodule

`default_nettype wire

// File: verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

	////////////////////////////////////////////////////////////
	// Datapath geometry
	////////////////////////////////////////////////////////////

	localparam int DATA_W = 32;
	localparam int REG_N  = 16;
	localparam int REG_AW = 4;

	// Multiply length in shift-add iterations
	localparam int MUL_CYCLES = 32;
	localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);

	// Shift amount comes from the low bits of operand B
	localparam int SHAMT_W = 5;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	// Opcodes on the issue port
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SLL = 3'd5,
		OP_SRL = 3'd6,
		OP_MUL = 3'd7
	} opcode_t;

	// Operand source, SEL_IMM only valid for B
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_t;

	typedef enum logic [1:0] {
		FRZ_RUN    = 2'd0,
		FRZ_MUL    = 2'd1,
		FRZ_FINISH = 2'd2
	} frz_state_t;

endpackage

`default_nettype wire

// File: verilog/exec_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_assert.svh"

module exec_regfile (
	input  wire                  clk,
	input  wire                  reset,
	input  wire exec_pkg::reg_addr_t rd_addr_a,
	input  wire exec_pkg::reg_addr_t rd_addr_b,
	input  wire                  wr_en,
	input  wire exec_pkg::reg_addr_t wr_addr,
	input  wire exec_pkg::word_t wr_data,
	output exec_pkg::word_t      rd_data_a,
	output exec_pkg::word_t      rd_data_b
);

	import exec_pkg::*;

	// Flop based storage, entry 0 is never written
	word_t regs [REG_N];

	// Write lands at the edge, no write-through
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Combinational reads, r0 reads zero
	assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

	`EXEC_ASSERT(a_wr_addr_known, clk, reset, wr_en |-> !$isunknown(wr_addr),
		"register file write to unknown address")

endmodule

`default_nettype wire

// File: verilog/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_assert.svh"

module exec_top (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      in_valid,
	input  wire exec_pkg::opcode_t   in_op,
	input  wire exec_pkg::reg_addr_t in_rd,
	input  wire exec_pkg::reg_addr_t in_ra,
	input  wire exec_pkg::reg_addr_t in_rb,
	input  wire exec_pkg::word_t     in_imm,
	input  wire                      in_use_imm,
	output logic                     in_ready,
	output logic                     out_valid,
	output exec_pkg::reg_addr_t      out_rd,
	output exec_pkg::word_t          out_data
);

	import exec_pkg::*;

	word_t     rf_dataa;
	word_t     rf_datab;
	word_t     operand_a;
	word_t     operand_b;
	word_t     alu_result;
	word_t     mul_product;
	word_t     ex_forw;
	word_t     wb_forw;
	sel_t      sel_a;
	sel_t      sel_b;
	opcode_t   ex_op;
	reg_addr_t wb_rd;
	logic      ex_valid;
	logic      wb_valid;
	logic      id_freeze;
	logic      ex_freeze;
	logic      mul_start;
	logic      mul_busy;
	logic      mul_done;

	////////////////////////////////////////////////////////////
	// Stage registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_op   <= OP_ADD;
			wb_forw <= '0;
		end else if (!ex_freeze) begin
			ex_op   <= in_op;
			wb_forw <= ex_forw;
		end
	end

	// EX result, product is final once the multiplier is done
	assign ex_forw = (ex_op == OP_MUL) ? mul_product : alu_result;

	assign in_ready  = !id_freeze;
	assign out_valid = wb_valid;
	assign out_rd    = wb_rd;
	assign out_data  = wb_forw;

	exec_regfile u_regfile (
		.clk       (clk),
		.reset     (reset),
		.rd_addr_a (in_ra),
		.rd_addr_b (in_rb),
		.wr_en     (wb_valid),
		.wr_addr   (wb_rd),
		.wr_data   (wb_forw),
		.rd_data_a (rf_dataa),
		.rd_data_b (rf_datab)
	);

	exec_fwd_ctrl u_fwd_ctrl (
		.clk        (clk),
		.reset      (reset),
		.id_freeze  (id_freeze),
		.ex_freeze  (ex_freeze),
		.in_valid   (in_valid),
		.in_rd      (in_rd),
		.in_ra      (in_ra),
		.in_rb      (in_rb),
		.in_use_imm (in_use_imm),
		.sel_a      (sel_a),
		.sel_b      (sel_b),
		.ex_valid   (ex_valid),
		.ex_rd      (),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd)
	);

	exec_operand_muxes u_operand_muxes (
		.clk       (clk),
		.reset     (reset),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_dataa  (rf_dataa),
		.rf_datab  (rf_datab),
		.ex_forw   (ex_forw),
		.wb_forw   (wb_forw),
		.simm      (in_imm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	exec_alu u_alu (
		.op        (ex_op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.result    (alu_result)
	);

	exec_mul u_mul (
		.clk       (clk),
		.reset     (reset),
		.start     (mul_start),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.product   (mul_product),
		.busy      (mul_busy),
		.done      (mul_done)
	);

	exec_freeze_ctrl u_freeze_ctrl (
		.clk       (clk),
		.reset     (reset),
		.ex_valid  (ex_valid),
		.ex_op     (ex_op),
		.mul_done  (mul_done),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.mul_start (mul_start)
	);

	// Whole pipeline stays frozen while the multiplier iterates
	`EXEC_ASSERT(a_busy_frozen, clk, reset, mul_busy |-> (id_freeze && ex_freeze),
		"pipeline moved during a multiply")

endmodule

`default_nettype wire
